/* filelist.f */
common/vlsu_pkg.sv
load_store/load_extender.sv
load_store/access_decoder.sv
load_store/lane_extractor.sv
load_store/load_collector.sv
design/fence_controller.sv
design/vlsu_top.sv
test/dcache_model.sv
test/vlsu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the load-store unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module vlsu_tb -o vlsu_sim

status=0
output=$(./obj_dir/vlsu_sim 2>&1) || status=$?
echo "$output"

if [ "$status" -ne 0 ] || ! grep -q "ALL CHECKS PASSED" <<< "$output"; then
    exit 1
fi
exit 0

/* test/vlsu_tb.sv */
// testbench for the vector load-store unit
// runs a table of scalar loads, stores, vector loads and fences against
// a behavioural data cache and checks results against a shadow memory

`timescale 1ns/1ps

module vlsu_tb import vlsu_pkg::*; ();

    localparam int IFLUSH_LAT = 3;
    localparam int DFLUSH_LAT = 5;

    localparam logic [1:0] OP_LOAD  = 2'd0;
    localparam logic [1:0] OP_STORE = 2'd1;
    localparam logic [1:0] OP_VLOAD = 2'd2;
    localparam logic [1:0] OP_FENCE = 2'd3;

    // offs holds one 4-bit byte offset per lane with lane 0 lowest
    typedef struct packed {
        logic [1:0]  op;
        load_type_e  lt;
        word_t       addr;
        logic [15:0] offs;
        lane_mask_t  ven;
        word_t       data;
    } row_t;

    logic                    CLK;
    logic                    nRST;
    logic                    ren;
    logic                    wen;
    word_t                   addr;
    load_type_e              load_type;
    word_t                   store_data;
    word_t [NUM_LANES-1:0]   addr_wide;
    lane_mask_t              ven_lanes;
    logic                    ifence;
    logic                    bus_ren;
    logic                    bus_wen;
    word_t                   bus_addr;
    byte_en_t                bus_byte_en;
    word_t                   bus_wdata;
    word_t                   bus_rdata;
    word_t [BLOCK_WORDS-1:0] bus_rdata_wide;
    logic                    bus_busy;
    logic                    icache_flush;
    logic                    dcache_flush;
    logic                    iflush_done;
    logic                    dflush_done;
    logic                    mal_addr;
    logic                    lsc_ready;
    logic                    load_valid;
    word_t                   dload_ext;
    word_t [NUM_LANES-1:0]   dload_ext_wide;
    logic                    fence_stall;

    row_t   table_q[$];
    word_t  shadow [16];
    integer seed;
    int     cycle_count = 0;
    int     cycle_limit = 1000;
    int     busy_cycles = 0;
    int     fail_count = 0;

    vlsu_top dut (.*);

    dcache_model #(
        .IFLUSH_LAT (IFLUSH_LAT),
        .DFLUSH_LAT (DFLUSH_LAT)
    ) u_cache (
        .CLK          (CLK),
        .nRST         (nRST),
        .ren          (bus_ren),
        .wen          (bus_wen),
        .addr         (bus_addr),
        .byte_en      (bus_byte_en),
        .wdata        (bus_wdata),
        .rdata        (bus_rdata),
        .rdata_wide   (bus_rdata_wide),
        .busy         (bus_busy),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic fail_stop(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    // run limit scales with the table length
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            fail_stop($sformatf("timeout, run still going after %0d cycles", cycle_count));
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else fail_stop($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp)
        else fail_stop($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    // extension of the addressed field or zero when misaligned
    function automatic word_t ref_extend(input load_type_e lt, input word_t w,
                                         input logic [1:0] off);
        word_t sh;
        sh = w >> {off, 3'b000};
        case (lt)
            LB:      return {{24{sh[7]}}, sh[7:0]};
            LBU:     return {24'h0, sh[7:0]};
            LH:      return off[0] ? 32'h0 : {{16{sh[15]}}, sh[15:0]};
            LHU:     return off[0] ? 32'h0 : {16'h0, sh[15:0]};
            LW:      return (off == 2'b00) ? w : 32'h0;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic ref_misaligned(input load_type_e lt, input logic [1:0] off);
        return ((lt == LW) && (off != 2'b00)) || (((lt == LH) || (lt == LHU)) && off[0]);
    endfunction

    function automatic byte_en_t ref_byte_en(input load_type_e lt, input logic [1:0] off);
        case (lt)
            LB, LBU: return 4'b0001 << off;
            LH, LHU: return off[0] ? 4'b0000 : (off[1] ? 4'b1100 : 4'b0011);
            LW:      return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic word_t ref_wdata(input load_type_e lt, input word_t d);
        case (lt)
            LB:      return {4{d[7:0]}};
            LH:      return {2{d[15:0]}};
            LW:      return d;
            default: return 32'h0;
        endcase
    endfunction

    task automatic add_row(input logic [1:0] op, input load_type_e lt, input word_t a,
                           input logic [15:0] offs, input lane_mask_t ven, input word_t d);
        row_t r;
        r.op   = op;
        r.lt   = lt;
        r.addr = a;
        r.offs = offs;
        r.ven  = ven;
        r.data = d;
        table_q.push_back(r);
    endtask

    task automatic build_table();
        load_type_e sizes [5];
        sizes = '{LB, LH, LW, LBU, LHU};
        // every scalar load type at every byte offset
        for (int t = 0; t < 5; t++) begin
            for (int o = 0; o < 4; o++) begin
                add_row(OP_LOAD, sizes[t], word_t'(((t * 5 + o * 3) % 16) * 4 + o),
                        16'h0, 4'h0, 32'h0);
            end
        end
        // stores of each size with a word readback
        add_row(OP_STORE, LB, 32'h05, 16'h0, 4'h0, 32'h123456a5);
        add_row(OP_LOAD,  LW, 32'h04, 16'h0, 4'h0, 32'h0);
        add_row(OP_STORE, LB, 32'h0b, 16'h0, 4'h0, 32'h0000007e);
        add_row(OP_LOAD,  LW, 32'h08, 16'h0, 4'h0, 32'h0);
        add_row(OP_STORE, LH, 32'h0c, 16'h0, 4'h0, 32'hffff8001);
        add_row(OP_LOAD,  LW, 32'h0c, 16'h0, 4'h0, 32'h0);
        add_row(OP_STORE, LH, 32'h12, 16'h0, 4'h0, 32'h0000beef);
        add_row(OP_LOAD,  LW, 32'h10, 16'h0, 4'h0, 32'h0);
        add_row(OP_STORE, LW, 32'h14, 16'h0, 4'h0, 32'hcafe1234);
        add_row(OP_LOAD,  LW, 32'h14, 16'h0, 4'h0, 32'h0);
        add_row(OP_FENCE, LT_NONE, 32'h0, 16'h0, 4'h0, 32'h0);
        // vector loads inside one block with mixed masks
        add_row(OP_VLOAD, LW,  32'h00, 16'hc840, 4'b1111, 32'h0);
        add_row(OP_VLOAD, LB,  32'h10, 16'hfa71, 4'b1011, 32'h0);
        add_row(OP_VLOAD, LHU, 32'h20, 16'h6e02, 4'b0110, 32'h0);
        add_row(OP_VLOAD, LH,  32'h30, 16'h2a60, 4'b1101, 32'h0);
        add_row(OP_VLOAD, LBU, 32'h30, 16'h9c53, 4'b1111, 32'h0);
        add_row(OP_VLOAD, LW,  32'h10, 16'h40cc, 4'b0101, 32'h0);
        add_row(OP_FENCE, LT_NONE, 32'h0, 16'h0, 4'h0, 32'h0);
    endtask

    task automatic do_access(input row_t r);
        word_t    lane_addr;
        word_t    exp_wide [NUM_LANES];
        word_t    exp_scalar;
        word_t    exp_wdata;
        byte_en_t exp_be;
        logic     exp_mal;
        logic     ready;
        exp_mal    = ref_misaligned(r.lt, r.addr[1:0]);
        exp_be     = ref_byte_en(r.lt, r.addr[1:0]);
        exp_wdata  = ref_wdata(r.lt, r.data);
        exp_scalar = ref_extend(r.lt, shadow[r.addr[5:2]], r.addr[1:0]);
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_addr   = r.addr + word_t'(r.offs[4*k +: 4]);
            exp_wide[k] = r.ven[k] ?
                ref_extend(r.lt, shadow[lane_addr[5:2]], lane_addr[1:0]) : 32'h0;
        end
        @(posedge CLK);
        ren        <= (r.op != OP_STORE);
        wen        <= (r.op == OP_STORE);
        addr       <= r.addr;
        load_type  <= r.lt;
        store_data <= r.data;
        ven_lanes  <= r.ven;
        for (int k = 0; k < NUM_LANES; k++) begin
            addr_wide[k] <= r.addr + word_t'(r.offs[4*k +: 4]);
        end
        // request held until the cache accepts it
        ready = 1'b0;
        while (!ready) begin
            @(negedge CLK);
            check_bit("bus_ren", bus_ren, r.op != OP_STORE);
            check_bit("bus_wen", bus_wen, r.op == OP_STORE);
            check_word("bus_addr", bus_addr, r.addr);
            check_bit("mal_addr", mal_addr, exp_mal);
            check_word("bus_byte_en", word_t'(bus_byte_en), word_t'(exp_be));
            if (r.op == OP_STORE) begin
                check_word("bus_wdata", bus_wdata, exp_wdata);
            end
            check_bit("lsc_ready", lsc_ready, !bus_busy);
            check_bit("load_valid", load_valid, 1'b0);
            ready = lsc_ready;
            if (!ready) begin
                busy_cycles++;
            end
        end
        @(posedge CLK);
        ren <= 1'b0;
        wen <= 1'b0;
        if (r.op == OP_STORE) begin
            for (int k = 0; k < 4; k++) begin
                if (exp_be[k]) begin
                    shadow[r.addr[5:2]][8*k +: 8] = exp_wdata[8*k +: 8];
                end
            end
        end
        @(negedge CLK);
        check_bit("load_valid", load_valid, r.op != OP_STORE);
        if (r.op != OP_STORE) begin
            check_word("dload_ext", dload_ext, exp_scalar);
            for (int k = 0; k < NUM_LANES; k++) begin
                check_word($sformatf("dload_ext_wide[%0d]", k), dload_ext_wide[k], exp_wide[k]);
            end
        end
    endtask

    // stall covers the cycles up to the later done pulse
    task automatic do_fence();
        int last_done;
        last_done = (IFLUSH_LAT > DFLUSH_LAT) ? IFLUSH_LAT : DFLUSH_LAT;
        @(posedge CLK);
        ifence <= 1'b1;
        for (int c = 0; c <= last_done + 2; c++) begin
            @(negedge CLK);
            check_bit("icache_flush", icache_flush, c == 0);
            check_bit("dcache_flush", dcache_flush, c == 0);
            check_bit("fence_stall", fence_stall, (c >= 1) && (c <= last_done));
        end
        @(posedge CLK);
        ifence <= 1'b0;
        @(negedge CLK);
        check_bit("fence_stall", fence_stall, 1'b0);
        check_bit("icache_flush", icache_flush, 1'b0);
    endtask

    initial begin
        nRST       <= 1'b0;
        ren        <= 1'b0;
        wen        <= 1'b0;
        addr       <= '0;
        load_type  <= LT_NONE;
        store_data <= '0;
        addr_wide  <= '0;
        ven_lanes  <= '0;
        ifence     <= 1'b0;
        // same fill sequence as the cache model
        seed = 78;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = $random(seed);
        end
        build_table();
        cycle_limit = table_q.size() * 10 + 100;
        repeat (8) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_bit("load_valid", load_valid, 1'b0);
        check_bit("fence_stall", fence_stall, 1'b0);
        check_bit("icache_flush", icache_flush, 1'b0);
        check_bit("dcache_flush", dcache_flush, 1'b0);
        foreach (table_q[i]) begin
            if (table_q[i].op == OP_FENCE) begin
                do_fence();
            end else begin
                do_access(table_q[i]);
            end
        end
        assert (busy_cycles > 0)
        else fail_stop("the cache never raised busy, back-pressure was not exercised");
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* test/dcache_model.sv */
// behavioural data cache for the load-store unit testbench
// 16-word memory with a random busy latency per request, block reads,
// byte-enabled writes and fixed flush done delays

`timescale 1ns/1ps

module dcache_model import vlsu_pkg::*; #(
    parameter int IFLUSH_LAT = 3,
    parameter int DFLUSH_LAT = 5
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    ren,
    input  logic                    wen,
    input  word_t                   addr,
    input  byte_en_t                byte_en,
    input  word_t                   wdata,
    output word_t                   rdata,
    output word_t [BLOCK_WORDS-1:0] rdata_wide,
    output logic                    busy,
    input  logic                    icache_flush,
    input  logic                    dcache_flush,
    output logic                    iflush_done,
    output logic                    dflush_done
);

    word_t                 mem [16];
    integer                seed;
    logic                  req;
    logic [1:0]            lat;
    logic [1:0]            cnt;
    logic [IFLUSH_LAT-1:0] ipipe;
    logic [DFLUSH_LAT-1:0] dpipe;

    initial begin
        seed = 78;
        for (int i = 0; i < 16; i++) begin
            mem[i] = $random(seed);
        end
    end

    assign req = ren | wen;

    // busy until the latency picked for this request has elapsed
    assign busy  = req & (cnt < lat);
    assign rdata = mem[addr[5:2]];

    always_comb begin
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            rdata_wide[i] = mem[{addr[5:4], 2'(i)}];
        end
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            cnt <= '0;
            lat <= 2'd1;
        end else if (req) begin
            if (busy) begin
                cnt <= cnt + 2'd1;
            end else begin
                // access done, latency for the next one
                cnt <= '0;
                lat <= 2'($unsigned($random(seed)) % 4);
            end
        end
    end

    // store lands on the completing edge
    always @(posedge CLK) begin
        if (wen && !busy) begin
            for (int k = 0; k < 4; k++) begin
                if (byte_en[k]) begin
                    mem[addr[5:2]][8*k +: 8] = wdata[8*k +: 8];
                end
            end
        end
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ipipe <= '0;
            dpipe <= '0;
        end else begin
            ipipe <= {ipipe[IFLUSH_LAT-2:0], icache_flush};
            dpipe <= {dpipe[DFLUSH_LAT-2:0], dcache_flush};
        end
    end

    assign iflush_done = ipipe[IFLUSH_LAT-1];
    assign dflush_done = dpipe[DFLUSH_LAT-1];

endmodule

/* design/vlsu_top.sv */
// vector load-store unit top level
// scalar access decoder, one extractor per vector lane, load result
// collector and the fence controller for cache flushes

`timescale 1ns/1ps

module vlsu_top import vlsu_pkg::*; (
    input  logic                      CLK,
    input  logic                      nRST,
    // pipeline request
    input  logic                      ren,
    input  logic                      wen,
    input  word_t                     addr,
    input  load_type_e                load_type,
    input  word_t                     store_data,
    input  word_t [NUM_LANES-1:0]     addr_wide,
    input  lane_mask_t                ven_lanes,
    input  logic                      ifence,
    // data cache bus
    output logic                      bus_ren,
    output logic                      bus_wen,
    output word_t                     bus_addr,
    output byte_en_t                  bus_byte_en,
    output word_t                     bus_wdata,
    input  word_t                     bus_rdata,
    input  word_t [BLOCK_WORDS-1:0]   bus_rdata_wide,
    input  logic                      bus_busy,
    // cache control
    output logic                      icache_flush,
    output logic                      dcache_flush,
    input  logic                      iflush_done,
    input  logic                      dflush_done,
    // results to the pipeline
    output logic                      mal_addr,
    output logic                      lsc_ready,
    output logic                      load_valid,
    output word_t                     dload_ext,
    output word_t [NUM_LANES-1:0]     dload_ext_wide,
    output logic                      fence_stall
);

    byte_en_t              byte_en;
    word_t [NUM_LANES-1:0] lane_data;

    assign lsc_ready = ~bus_busy;

    access_decoder u_decoder (
        .ren         (ren),
        .wen         (wen),
        .addr        (addr),
        .load_type   (load_type),
        .store_data  (store_data),
        .bus_ren     (bus_ren),
        .bus_wen     (bus_wen),
        .bus_addr    (bus_addr),
        .bus_byte_en (bus_byte_en),
        .bus_wdata   (bus_wdata),
        .mal_addr    (mal_addr),
        .byte_en     (byte_en)
    );

    // all lanes read from the same returned block
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_extractor u_lane (
            .lane_addr  (addr_wide[i]),
            .lane_en    (ven_lanes[i]),
            .load_type  (load_type),
            .block_data (bus_rdata_wide),
            .lane_data  (lane_data[i])
        );
    end

    load_collector u_collector (
        .CLK            (CLK),
        .nRST           (nRST),
        .ren            (ren),
        .bus_busy       (bus_busy),
        .load_type      (load_type),
        .byte_en        (byte_en),
        .bus_rdata      (bus_rdata),
        .lane_data      (lane_data),
        .load_valid     (load_valid),
        .dload_ext      (dload_ext),
        .dload_ext_wide (dload_ext_wide)
    );

    fence_controller u_fence (
        .CLK          (CLK),
        .nRST         (nRST),
        .ifence       (ifence),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .fence_stall  (fence_stall)
    );

endmodule

/* design/fence_controller.sv */
// instruction fence controller
// turns the rising edge of ifence into flush pulses for both caches and
// stalls the pipeline until both caches have reported done

`timescale 1ns/1ps

module fence_controller (
    input  logic CLK,
    input  logic nRST,
    input  logic ifence,
    input  logic iflush_done,
    input  logic dflush_done,
    output logic icache_flush,
    output logic dcache_flush,
    output logic fence_stall
);

    logic ifence_reg;
    logic ifence_pulse;
    logic iflushed;
    logic iflushed_next;
    logic dflushed;
    logic dflushed_next;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ifence_reg <= 1'b0;
            iflushed   <= 1'b1;
            dflushed   <= 1'b1;
        end else begin
            ifence_reg <= ifence;
            iflushed   <= iflushed_next;
            dflushed   <= dflushed_next;
        end
    end

    // first cycle of the fence only
    assign ifence_pulse = ifence & ~ifence_reg;
    assign icache_flush = ifence_pulse;
    assign dcache_flush = ifence_pulse;

    // flags drop on a new fence, done pulses win if they coincide
    always_comb begin
        iflushed_next = iflushed;
        dflushed_next = dflushed;
        if (ifence_pulse) begin
            iflushed_next = 1'b0;
            dflushed_next = 1'b0;
        end
        if (iflush_done) begin
            iflushed_next = 1'b1;
        end
        if (dflush_done) begin
            dflushed_next = 1'b1;
        end
    end

    assign fence_stall = ifence_reg & ~(iflushed & dflushed);

endmodule

/* load_store/load_collector.sv */
// load result collector
// extends the scalar read word and captures the scalar and all vector
// lane results on a completing read, with a one-cycle valid pulse

`timescale 1ns/1ps

module load_collector import vlsu_pkg::*; (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    ren,
    input  logic                    bus_busy,
    input  load_type_e              load_type,
    input  byte_en_t                byte_en,
    input  word_t                   bus_rdata,
    input  word_t [NUM_LANES-1:0]   lane_data,
    output logic                    load_valid,
    output word_t                   dload_ext,
    output word_t [NUM_LANES-1:0]   dload_ext_wide
);

    word_t scalar_ext;
    logic  read_done;

    load_extender u_scalar_ext (
        .data_in   (bus_rdata),
        .load_type (load_type),
        .byte_en   (byte_en),
        .ext_out   (scalar_ext)
    );

    // read completes once the cache drops busy
    assign read_done = ren & ~bus_busy;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= read_done;
        end
    end

    // results hold until the next completing read
    always_ff @(posedge CLK) begin
        if (read_done) begin
            dload_ext      <= scalar_ext;
            dload_ext_wide <= lane_data;
        end
    end

endmodule

/* load_store/lane_extractor.sv */
// vector lane extractor
// selects one lane's word out of the returned cache block, applies the
// lane enable and extends the addressed byte, halfword or word

`timescale 1ns/1ps

module lane_extractor import vlsu_pkg::*; (
    input  word_t                    lane_addr,
    input  logic                     lane_en,
    input  load_type_e               load_type,
    input  word_t [BLOCK_WORDS-1:0]  block_data,
    output word_t                    lane_data
);

    block_idx_t word_idx;
    word_t      word_sel;
    byte_en_t   lane_byte_en;

    // word index within the block starts at address bit 2
    assign word_idx = lane_addr[BLOCK_IDX_BITS+1:2];

    // disabled lanes read as zero
    assign word_sel = lane_en ? block_data[word_idx] : '0;

    // same enable rule as the scalar path, from this lane's own offset
    assign lane_byte_en = gen_byte_en(load_type, lane_addr[1:0]);

    load_extender u_lane_ext (
        .data_in   (word_sel),
        .load_type (load_type),
        .byte_en   (lane_byte_en),
        .ext_out   (lane_data)
    );

endmodule

/* load_store/access_decoder.sv */
// scalar access decoder
// forwards a load or store to the data cache bus, builds the byte enables,
// flags misaligned accesses and replicates store data across the bus word

`timescale 1ns/1ps

module access_decoder import vlsu_pkg::*; (
    input  logic       ren,
    input  logic       wen,
    input  word_t      addr,
    input  load_type_e load_type,
    input  word_t      store_data,
    output logic       bus_ren,
    output logic       bus_wen,
    output word_t      bus_addr,
    output byte_en_t   bus_byte_en,
    output word_t      bus_wdata,
    output logic       mal_addr,
    output byte_en_t   byte_en
);

    logic [1:0] byte_offset;
    byte_en_t   req_byte_en;

    assign byte_offset = addr[1:0];

    // request goes straight through, the cache handles busy
    assign bus_ren  = ren;
    assign bus_wen  = wen;
    assign bus_addr = addr;

    assign req_byte_en = gen_byte_en(load_type, byte_offset);
    assign bus_byte_en = req_byte_en;

    // word must be word aligned, halfword must sit on an even byte
    always_comb begin
        case (load_type)
            LW: begin
                mal_addr = (byte_offset != 2'b00);
            end
            LH, LHU: begin
                mal_addr = byte_offset[0];
            end
            default: begin
                mal_addr = 1'b0;
            end
        endcase
    end

    // enables for the load extender, cleared on a misaligned access
    // so the returned result is zero
    assign byte_en = mal_addr ? byte_en_t'(4'b0000) : req_byte_en;

    // replicate so every byte lane of the bus sees the store value
    always_comb begin
        case (load_type)
            LB: begin
                bus_wdata = {4{store_data[7:0]}};
            end
            LH: begin
                bus_wdata = {2{store_data[15:0]}};
            end
            LW: begin
                bus_wdata = store_data;
            end
            default: begin
                bus_wdata = '0;
            end
        endcase
    end

endmodule

/* load_store/load_extender.sv */
// load data extender
// picks the byte, halfword or word selected by the byte enables and
// sign or zero extends it to a full word

`timescale 1ns/1ps

module load_extender import vlsu_pkg::*; (
    input  word_t      data_in,
    input  load_type_e load_type,
    input  byte_en_t   byte_en,
    output word_t      ext_out
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic        byte_hit;
    logic        half_hit;

    // one-hot byte enable
    always_comb begin
        byte_hit = 1'b1;
        case (byte_en)
            4'b0001: sel_byte = data_in[7:0];
            4'b0010: sel_byte = data_in[15:8];
            4'b0100: sel_byte = data_in[23:16];
            4'b1000: sel_byte = data_in[31:24];
            default: begin
                sel_byte = '0;
                byte_hit = 1'b0;
            end
        endcase
    end

    // lower or upper halfword
    always_comb begin
        half_hit = 1'b1;
        case (byte_en)
            4'b0011: sel_half = data_in[15:0];
            4'b1100: sel_half = data_in[31:16];
            default: begin
                sel_half = '0;
                half_hit = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (load_type)
            LB:      ext_out = byte_hit ? {{24{sel_byte[7]}}, sel_byte} : '0;
            LBU:     ext_out = byte_hit ? {24'b0, sel_byte} : '0;
            LH:      ext_out = half_hit ? {{16{sel_half[15]}}, sel_half} : '0;
            LHU:     ext_out = half_hit ? {16'b0, sel_half} : '0;
            LW:      ext_out = (byte_en == 4'b1111) ? data_in : '0;
            default: ext_out = '0;
        endcase
    end

endmodule

/* common/vlsu_pkg.sv */
// vector load-store unit shared definitions
// data widths, lane count, cache block geometry, load types and the
// byte enable rule used by both the scalar decoder and the vector lanes

package vlsu_pkg;

    // 32-bit data and address word
    typedef logic [31:0] word_t;

    // one enable bit per byte, byte k is bits 8k+7..8k
    typedef logic [3:0] byte_en_t;

    localparam int NUM_LANES = 4;

    // data cache block geometry
    localparam int BLOCK_WORDS = 4;
    localparam int BLOCK_IDX_BITS = $clog2(BLOCK_WORDS) + (BLOCK_WORDS == 1);

    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [BLOCK_IDX_BITS-1:0] block_idx_t;

    // stores reuse LB, LH and LW as the access size
    typedef enum logic [2:0] {
        LT_NONE = 3'd0,
        LB      = 3'd1,
        LH      = 3'd2,
        LW      = 3'd3,
        LBU     = 3'd4,
        LHU     = 3'd5
    } load_type_e;

    // byte enables from access size and the low address bits
    function automatic byte_en_t gen_byte_en(input load_type_e load_type,
                                             input logic [1:0] offset);
        byte_en_t be;
        be = '0;
        case (load_type)
            LB, LBU: begin
                be = byte_en_t'(4'b0001 << offset);
            end
            LH, LHU: begin
                case (offset)
                    2'b00:   be = 4'b0011;
                    2'b10:   be = 4'b1100;
                    default: be = 4'b0000;
                endcase
            end
            LW: begin
                be = 4'b1111;
            end
            default: begin
                be = 4'b0000;
            end
        endcase
        return be;
    endfunction

endpackage
